//--- Bender.yml
package:
  name: dlx_pipeline

sources:
  - hw/dlx_pkg.sv
  - hw/fetch_stage.sv
  - hw/decode_stage.sv
  - hw/execute_stage.sv
  - hw/memory_stage.sv
  - hw/writeback_stage.sv
  - hw/dlx_pipeline.sv
  - target: test
    files:
      - testbench/tb_dlx_pipeline.sv

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     freeze,
  input  dlx_pkg::if_id_t          if_id,
  input  dlx_pkg::id_ex_t          id_ex_cur,
  input  dlx_pkg::fwd_t            ex_fwd,
  input  dlx_pkg::fwd_t            wb_fwd,
  input  dlx_pkg::reg_wr_t         wb_wr,
  output dlx_pkg::id_ex_t          id_ex_next,
  output logic                     stall,
  output logic                     redirect_en,
  output logic [dlx_pkg::xlen-1:0] redirect_pc
);
  import dlx_pkg::*;

  opcode_e         op;
  func_e           fn;
  ctrl_t           ctrl;
  reg_addr_t       src1;
  reg_addr_t       src2;
  reg_addr_t       ex_dest;
  logic            use_rs1;
  logic            use_rs2;
  logic            is_beqz;
  logic            is_bnez;
  logic            is_jump;
  logic            is_jreg;
  logic            ex_writes;
  logic            load_use;
  logic            br_hazard;
  logic            taken;
  logic [xlen-1:0] regs [32];
  logic [xlen-1:0] rf_a;
  logic [xlen-1:0] rf_b;
  logic [xlen-1:0] br_opa;
  logic [xlen-1:0] offset;

  assign op   = opcode_e'(if_id.instr[31:26]);
  assign fn   = func_e'(if_id.instr[5:0]);
  assign src1 = if_id.instr[25:21];
  assign src2 = if_id.instr[20:16];

  //////////////////////////////////////////////////
  // control decode
  //////////////////////////////////////////////////
  always_comb begin
    ctrl    = '0;
    use_rs1 = 1'b1;
    use_rs2 = 1'b0;
    is_beqz = 1'b0;
    is_bnez = 1'b0;
    is_jump = 1'b0;
    is_jreg = 1'b0;
    case (op)
      op_rtype: begin
        ctrl.r_type = 1'b1;
        ctrl.reg_wr = 1'b1;
        use_rs2     = 1'b1;
        case (fn)
          fn_add:  ctrl.alu_op = alu_add;
          fn_sub:  ctrl.alu_op = alu_sub;
          fn_and:  ctrl.alu_op = alu_and;
          fn_or:   ctrl.alu_op = alu_or;
          fn_xor:  ctrl.alu_op = alu_xor;
          fn_sll:  ctrl.alu_op = alu_sll;
          fn_srl:  ctrl.alu_op = alu_srl;
          fn_sra:  ctrl.alu_op = alu_sra;
          fn_slt:  ctrl.alu_op = alu_slt;
          fn_sltu: ctrl.alu_op = alu_sltu;
          // unknown function acts as a nop
          default: ctrl.reg_wr = 1'b0;
        endcase
      end
      op_addi, op_slti, op_andi, op_ori, op_xori, op_lhi: begin
        ctrl.reg_wr       = 1'b1;
        ctrl.use_imm      = 1'b1;
        // logical immediates are zero extended
        ctrl.imm_zero_ext = op inside {op_andi, op_ori, op_xori};
        ctrl.lhi          = (op == op_lhi);
        use_rs1           = (op != op_lhi);
        case (op)
          op_slti: ctrl.alu_op = alu_slt;
          op_andi: ctrl.alu_op = alu_and;
          op_ori:  ctrl.alu_op = alu_or;
          op_xori: ctrl.alu_op = alu_xor;
          op_lhi:  ctrl.alu_op = alu_pass_b;
          default: ctrl.alu_op = alu_add;
        endcase
      end
      op_lb, op_lh, op_lw, op_lbu, op_lhu: begin
        ctrl.reg_wr      = 1'b1;
        ctrl.mem_rd      = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
        ctrl.use_imm     = 1'b1;
        ctrl.load_signed = op inside {op_lb, op_lh};
        ctrl.mem_size    = (op inside {op_lb, op_lbu}) ? size_byte :
                           (op inside {op_lh, op_lhu}) ? size_half : size_word;
      end
      op_sb, op_sh, op_sw: begin
        ctrl.mem_wr   = 1'b1;
        ctrl.use_imm  = 1'b1;
        use_rs2       = 1'b1;
        ctrl.mem_size = (op == op_sb) ? size_byte : (op == op_sh) ? size_half : size_word;
      end
      op_beqz: is_beqz = 1'b1;
      op_bnez: is_bnez = 1'b1;
      op_j, op_jal: begin
        is_jump     = 1'b1;
        use_rs1     = 1'b0;
        ctrl.reg_wr = (op == op_jal);
        ctrl.link   = (op == op_jal);
      end
      op_jr, op_jalr: begin
        is_jreg     = 1'b1;
        ctrl.reg_wr = (op == op_jalr);
        ctrl.link   = (op == op_jalr);
      end
      default: use_rs1 = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // register file, written at the edge
  //////////////////////////////////////////////////
  // write lands when writeback leaves, bypass covers the rest
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_wr.wr && wb_wr.rd != '0 && !freeze) begin
      regs[wb_wr.rd] <= wb_wr.data;
    end
  end

  // write-through, r0 never bypassed
  always_comb begin
    rf_a = regs[src1];
    rf_b = regs[src2];
    if (wb_wr.wr && wb_wr.rd != '0 && wb_wr.rd == src1) rf_a = wb_wr.data;
    if (wb_wr.wr && wb_wr.rd != '0 && wb_wr.rd == src2) rf_b = wb_wr.data;
  end

  //////////////////////////////////////////////////
  // hazards
  //////////////////////////////////////////////////
  assign ex_dest   = dest_reg(id_ex_cur);
  assign ex_writes = id_ex_cur.valid && id_ex_cur.ctrl.reg_wr && ex_dest != '0;
  // load in execute feeding this instruction
  assign load_use  = ex_writes && id_ex_cur.ctrl.mem_rd &&
                     ((use_rs1 && src1 == ex_dest) || (use_rs2 && src2 == ex_dest));
  // branch source still in execute, or a load still in memory
  assign br_hazard = (is_beqz || is_bnez || is_jreg) &&
                     ((ex_writes && src1 == ex_dest) ||
                      (ex_fwd.reg_wr && !ex_fwd.valid && ex_fwd.rd == src1 && src1 != '0));
  assign stall     = if_id.valid && (load_use || br_hazard);

  //////////////////////////////////////////////////
  // branch and jump resolution
  //////////////////////////////////////////////////
  assign br_opa = fwd_pick(src1, rf_a, ex_fwd, wb_fwd);
  assign offset = is_jump ? {{6{if_id.instr[25]}}, if_id.instr[25:0]}
                          : {{16{if_id.instr[15]}}, if_id.instr[15:0]};
  assign taken  = is_jump || is_jreg || (is_beqz && br_opa == '0) ||
                  (is_bnez && br_opa != '0);
  assign redirect_en = if_id.valid && taken && !stall;
  // relative to the delay slot
  assign redirect_pc = is_jreg ? br_opa : if_id.pc + 32'd4 + offset;

  // bubble on stall
  assign id_ex_next = '{valid: if_id.valid && !stall, ctrl: ctrl, rs1: src1, rs2: src2,
                        rd: if_id.instr[15:11], busa: rf_a, busb: rf_b,
                        imm32: {{16{if_id.instr[15]}}, if_id.instr[15:0]}, pc: if_id.pc};

  // r0 reads zero through array and bypass alike
  a_r0_zero: assert property (@(posedge clk) disable iff (!arst_n)
    (src1 != '0 || rf_a == '0) && (src2 != '0 || rf_b == '0));

endmodule

//--- hw/dlx_pipeline.sv
`timescale 1ns/1ps

module dlx_pipeline (
  input  logic              clk,
  input  logic              arst_n,
  output logic [31:0]       pc,
  input  logic [31:0]       instr,
  output dlx_pkg::apb_req_t apb_req,
  input  logic [31:0]       prdata,
  input  logic              pready
);
  import dlx_pkg::*;

  //////////////////////////////////////////////////
  // inter-stage wires
  //////////////////////////////////////////////////
  if_id_t          if_id;
  id_ex_t          id_ex_next;
  id_ex_t          id_ex_cur;
  ex_mem_t         ex_mem;
  mem_wb_t         mem_wb;
  // ex/mem view, one copy per consumer
  fwd_t            ex_fwd;
  fwd_t            mem_fwd;
  fwd_t            wb_fwd;
  reg_wr_t         wb_wr;
  logic            freeze;
  logic            stall;
  logic            redirect_en;
  logic [xlen-1:0] redirect_pc;

  fetch_stage i_fetch_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .freeze      (freeze),
    .stall       (stall),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .instr       (instr),
    .pc          (pc),
    .if_id       (if_id)
  );

  decode_stage i_decode_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .freeze      (freeze),
    .if_id       (if_id),
    .id_ex_cur   (id_ex_cur),
    .ex_fwd      (ex_fwd),
    .wb_fwd      (wb_fwd),
    .wb_wr       (wb_wr),
    .id_ex_next  (id_ex_next),
    .stall       (stall),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc)
  );

  execute_stage i_execute_stage (
    .clk        (clk),
    .arst_n     (arst_n),
    .freeze     (freeze),
    .id_ex_next (id_ex_next),
    .mem_fwd    (mem_fwd),
    .wb_fwd     (wb_fwd),
    .id_ex_cur  (id_ex_cur),
    .ex_fwd     (ex_fwd),
    .ex_mem     (ex_mem)
  );

  // apb wait states freeze the whole pipe
  memory_stage i_memory_stage (
    .clk     (clk),
    .arst_n  (arst_n),
    .ex_mem  (ex_mem),
    .apb_req (apb_req),
    .prdata  (prdata),
    .pready  (pready),
    .freeze  (freeze),
    .mem_fwd (mem_fwd),
    .mem_wb  (mem_wb)
  );

  writeback_stage i_writeback_stage (
    .mem_wb (mem_wb),
    .wb_fwd (wb_fwd),
    .wb_wr  (wb_wr)
  );

endmodule

//--- hw/dlx_pkg.sv
package dlx_pkg;

  //////////////////////////////////////////////////
  // widths and fixed registers
  //////////////////////////////////////////////////
  localparam int xlen = 32;

  typedef logic [4:0] reg_addr_t;

  // jal / jalr destination
  localparam reg_addr_t link_reg = 5'd31;

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////
  // primary opcodes, classic dlx numbering
  typedef enum logic [5:0] {
    op_rtype = 6'h00, op_j    = 6'h02, op_jal  = 6'h03, op_beqz = 6'h04,
    op_bnez  = 6'h05, op_addi = 6'h08, op_andi = 6'h0c, op_ori  = 6'h0d,
    op_xori  = 6'h0e, op_lhi  = 6'h0f, op_jr   = 6'h12, op_jalr = 6'h13,
    op_slti  = 6'h1a, op_lb   = 6'h20, op_lh   = 6'h21, op_lw   = 6'h23,
    op_lbu   = 6'h24, op_lhu  = 6'h25, op_sb   = 6'h28, op_sh   = 6'h29,
    op_sw    = 6'h2b
  } opcode_e;

  // r-type function field, instr[5:0]
  typedef enum logic [5:0] {
    fn_sll = 6'h04, fn_srl = 6'h06, fn_sra = 6'h07, fn_add  = 6'h20,
    fn_sub = 6'h22, fn_and = 6'h24, fn_or  = 6'h25, fn_xor  = 6'h26,
    fn_slt = 6'h2a, fn_sltu = 6'h2b
  } func_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll,
    alu_srl, alu_sra, alu_slt, alu_sltu, alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } mem_size_e;

  //////////////////////////////////////////////////
  // control word and pipeline registers
  //////////////////////////////////////////////////
  typedef struct packed {
    logic      reg_wr;
    logic      mem_rd;
    logic      mem_wr;
    mem_size_e mem_size;
    logic      load_signed;
    logic      mem_to_reg;
    logic      link;
    logic      lhi;
    logic      use_imm;
    logic      imm_zero_ext;
    logic      r_type;
    alu_op_e   alu_op;
  } ctrl_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [31:0]     instr;
  } if_id_t;

  typedef struct packed {
    logic            valid;
    ctrl_t           ctrl;
    reg_addr_t       rs1;
    reg_addr_t       rs2;
    reg_addr_t       rd;
    logic [xlen-1:0] busa;
    logic [xlen-1:0] busb;
    logic [xlen-1:0] imm32;
    logic [xlen-1:0] pc;
  } id_ex_t;

  typedef struct packed {
    logic            valid;
    ctrl_t           ctrl;
    reg_addr_t       rd;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] store_data;
    logic [xlen-1:0] pc;
    logic [15:0]     imm16;
  } ex_mem_t;

  typedef struct packed {
    logic            valid;
    ctrl_t           ctrl;
    reg_addr_t       rd;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] load_word;
    logic [1:0]      byte_off;
    logic [xlen-1:0] pc;
    logic [15:0]     imm16;
  } mem_wb_t;

  // apb4 requester outputs
  typedef struct packed {
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [xlen-1:0] paddr;
    logic [xlen-1:0] pwdata;
    logic [3:0]      pstrb;
  } apb_req_t;

  typedef struct packed {
    logic            wr;
    reg_addr_t       rd;
    logic [xlen-1:0] data;
  } reg_wr_t;

  // valid: value is final, reg_wr: stage will write rd
  typedef struct packed {
    logic            valid;
    logic            reg_wr;
    reg_addr_t       rd;
    logic [xlen-1:0] value;
  } fwd_t;

  //////////////////////////////////////////////////
  // helpers shared by several stages
  //////////////////////////////////////////////////
  // destination of an instruction in execute
  function automatic reg_addr_t dest_reg(id_ex_t e);
    if (e.ctrl.link) return link_reg;
    return e.ctrl.r_type ? e.rd : e.rs2;
  endfunction

  // non-load result, link and lhi override alu
  function automatic logic [xlen-1:0] result_of(ctrl_t c, logic [xlen-1:0] alu_out,
                                                logic [xlen-1:0] pc, logic [15:0] imm16);
    if (c.link) return pc + 32'd8;
    if (c.lhi) return {imm16, 16'h0000};
    return alu_out;
  endfunction

  // ex/mem view offered for forwarding, loads not ready yet
  function automatic fwd_t fwd_from_ex_mem(ex_mem_t e);
    fwd_t f;
    f.valid  = e.valid && !e.ctrl.mem_rd;
    f.reg_wr = e.valid && e.ctrl.reg_wr;
    f.rd     = e.rd;
    f.value  = result_of(e.ctrl, e.alu_out, e.pc, e.imm16);
    return f;
  endfunction

  // newest matching producer wins, r0 never matches
  function automatic logic [xlen-1:0] fwd_pick(reg_addr_t r, logic [xlen-1:0] v,
                                               fwd_t newer, fwd_t older);
    if (r == '0) return v;
    if (newer.valid && newer.reg_wr && newer.rd == r) return newer.value;
    if (older.valid && older.reg_wr && older.rd == r) return older.value;
    return v;
  endfunction

endpackage

//--- hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             freeze,
  input  dlx_pkg::id_ex_t  id_ex_next,
  input  dlx_pkg::fwd_t    mem_fwd,
  input  dlx_pkg::fwd_t    wb_fwd,
  output dlx_pkg::id_ex_t  id_ex_cur,
  output dlx_pkg::fwd_t    ex_fwd,
  output dlx_pkg::ex_mem_t ex_mem
);
  import dlx_pkg::*;

  logic [xlen-1:0] opa;
  logic [xlen-1:0] opb_reg;
  logic [xlen-1:0] opb;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] alu_res;

  //////////////////////////////////////////////////
  // id/ex register
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex_cur <= '0;
    end else if (!freeze) begin
      id_ex_cur <= id_ex_next;
    end
  end

  //////////////////////////////////////////////////
  // operand selection
  //////////////////////////////////////////////////
  // ex/mem first, then mem/wb
  assign opa     = fwd_pick(id_ex_cur.rs1, id_ex_cur.busa, mem_fwd, wb_fwd);
  assign opb_reg = fwd_pick(id_ex_cur.rs2, id_ex_cur.busb, mem_fwd, wb_fwd);
  // andi/ori/xori drop the sign
  assign imm     = id_ex_cur.ctrl.imm_zero_ext ? {16'h0000, id_ex_cur.imm32[15:0]}
                                               : id_ex_cur.imm32;
  assign opb     = id_ex_cur.ctrl.use_imm ? imm : opb_reg;

  //////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////
  always_comb begin
    case (id_ex_cur.ctrl.alu_op)
      alu_add:    alu_res = opa + opb;
      alu_sub:    alu_res = opa - opb;
      alu_and:    alu_res = opa & opb;
      alu_or:     alu_res = opa | opb;
      alu_xor:    alu_res = opa ^ opb;
      // shift amount from low five bits
      alu_sll:    alu_res = opa << opb[4:0];
      alu_srl:    alu_res = opa >> opb[4:0];
      alu_sra:    alu_res = $signed(opa) >>> opb[4:0];
      alu_slt:    alu_res = {31'b0, $signed(opa) < $signed(opb)};
      alu_sltu:   alu_res = {31'b0, opa < opb};
      alu_pass_b: alu_res = opb;
      default:    alu_res = opa + opb;
    endcase
  end

  //////////////////////////////////////////////////
  // ex/mem register
  //////////////////////////////////////////////////
  // store data carries the forwarded rs2
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_mem <= '0;
    end else if (!freeze) begin
      ex_mem.valid      <= id_ex_cur.valid;
      ex_mem.ctrl       <= id_ex_cur.ctrl;
      ex_mem.rd         <= dest_reg(id_ex_cur);
      ex_mem.alu_out    <= alu_res;
      ex_mem.store_data <= opb_reg;
      ex_mem.pc         <= id_ex_cur.pc;
      ex_mem.imm16      <= id_ex_cur.imm32[15:0];
    end
  end

  // decode resolves branches against this
  assign ex_fwd = fwd_from_ex_mem(ex_mem);

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     freeze,
  input  logic                     stall,
  input  logic                     redirect_en,
  input  logic [dlx_pkg::xlen-1:0] redirect_pc,
  input  logic [31:0]              instr,
  output logic [31:0]              pc,
  output dlx_pkg::if_id_t          if_id
);

  //////////////////////////////////////////////////
  // pc and if/id register
  //////////////////////////////////////////////////
  // instr arrives combinationally for the current pc
  // redirect lands after the delay slot is captured
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc    <= '0;
      if_id <= '0;
    end else if (!freeze && !stall) begin
      // taken branch or jump from decode
      if (redirect_en) begin
        pc <= redirect_pc;
      end else begin
        pc <= pc + 32'd4;
      end
      if_id.valid <= 1'b1;
      if_id.pc    <= pc;
      if_id.instr <= instr;
    end
  end

  // redirect targets must stay on word boundaries
  a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00);

endmodule

//--- hw/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
  input  logic              clk,
  input  logic              arst_n,
  input  dlx_pkg::ex_mem_t  ex_mem,
  output dlx_pkg::apb_req_t apb_req,
  input  logic [31:0]       prdata,
  input  logic              pready,
  output logic              freeze,
  output dlx_pkg::fwd_t     mem_fwd,
  output dlx_pkg::mem_wb_t  mem_wb
);
  import dlx_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access
  } apb_state_e;

  apb_state_e state_q;
  apb_state_e state;
  logic       mem_op;
  logic [1:0] off;

  assign mem_op = ex_mem.valid && (ex_mem.ctrl.mem_rd || ex_mem.ctrl.mem_wr);
  assign off    = ex_mem.alu_out[1:0];

  //////////////////////////////////////////////////
  // apb4 requester fsm
  //////////////////////////////////////////////////
  // setup starts in the cycle the access arrives
  always_comb begin
    state = state_q;
    if (state_q == st_idle && mem_op) state = st_setup;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
    end else begin
      case (state)
        st_setup:  state_q <= st_access;
        st_access: if (pready) state_q <= st_idle;
        default:   state_q <= st_idle;
      endcase
    end
  end

  // hold everything until the access completes
  assign freeze = (state == st_setup) || (state == st_access && !pready);

  //////////////////////////////////////////////////
  // request fields and byte lanes
  //////////////////////////////////////////////////
  always_comb begin
    apb_req.psel    = (state != st_idle);
    apb_req.penable = (state == st_access);
    apb_req.pwrite  = apb_req.psel && ex_mem.ctrl.mem_wr;
    apb_req.paddr   = {ex_mem.alu_out[xlen-1:2], 2'b00};
    // replicate onto every lane, strobe picks
    case (ex_mem.ctrl.mem_size)
      size_byte: begin
        apb_req.pwdata = {4{ex_mem.store_data[7:0]}};
        apb_req.pstrb  = 4'b0001 << off;
      end
      size_half: begin
        apb_req.pwdata = {2{ex_mem.store_data[15:0]}};
        apb_req.pstrb  = off[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        apb_req.pwdata = ex_mem.store_data;
        apb_req.pstrb  = 4'b1111;
      end
    endcase
    // reads carry no strobes
    if (!apb_req.pwrite) apb_req.pstrb = 4'b0000;
  end

  //////////////////////////////////////////////////
  // mem/wb register
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_wb <= '0;
    end else if (!freeze) begin
      mem_wb.valid     <= ex_mem.valid;
      mem_wb.ctrl      <= ex_mem.ctrl;
      mem_wb.rd        <= ex_mem.rd;
      mem_wb.alu_out   <= ex_mem.alu_out;
      mem_wb.load_word <= prdata;
      mem_wb.byte_off  <= off;
      mem_wb.pc        <= ex_mem.pc;
      mem_wb.imm16     <= ex_mem.imm16;
    end
  end

  assign mem_fwd = fwd_from_ex_mem(ex_mem);

  // access only with psel, and only after a setup cycle
  a_penable_psel: assert property (@(posedge clk) disable iff (!arst_n)
    apb_req.penable |-> (apb_req.psel && $past(apb_req.psel)));

  // address, direction, data and strobes hold until completion
  a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (apb_req.psel && !(apb_req.penable && pready)) |=>
      $stable({apb_req.paddr, apb_req.pwrite, apb_req.pwdata, apb_req.pstrb}));

endmodule

//--- hw/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
  input  dlx_pkg::mem_wb_t mem_wb,
  output dlx_pkg::fwd_t    wb_fwd,
  output dlx_pkg::reg_wr_t wb_wr
);
  import dlx_pkg::*;

  logic [7:0]      lane_b;
  logic [15:0]     lane_h;
  logic [xlen-1:0] load_val;
  logic [xlen-1:0] data;

  //////////////////////////////////////////////////
  // load extraction
  //////////////////////////////////////////////////
  // little-endian lanes, same as the store strobes
  assign lane_b = mem_wb.load_word[8*mem_wb.byte_off +: 8];
  assign lane_h = mem_wb.load_word[16*mem_wb.byte_off[1] +: 16];

  always_comb begin
    case (mem_wb.ctrl.mem_size)
      size_byte: load_val = {{24{mem_wb.ctrl.load_signed & lane_b[7]}}, lane_b};
      size_half: load_val = {{16{mem_wb.ctrl.load_signed & lane_h[15]}}, lane_h};
      default:   load_val = mem_wb.load_word;
    endcase
  end

  // alu, lhi or link result otherwise
  assign data = mem_wb.ctrl.mem_to_reg ? load_val
              : result_of(mem_wb.ctrl, mem_wb.alu_out, mem_wb.pc, mem_wb.imm16);

  //////////////////////////////////////////////////
  // write request and forward
  //////////////////////////////////////////////////
  assign wb_wr  = '{wr: mem_wb.valid && mem_wb.ctrl.reg_wr, rd: mem_wb.rd, data: data};
  assign wb_fwd = '{valid: mem_wb.valid, reg_wr: mem_wb.valid && mem_wb.ctrl.reg_wr,
                    rd: mem_wb.rd, value: data};

endmodule

//--- project.f
hw/dlx_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/writeback_stage.sv
hw/dlx_pipeline.sv
testbench/tb_dlx_pipeline.sv

//--- testbench/dlx_tests.txt
# record kinds: T name | P instr_word | D byte_addr word | E paddr pwdata pstrb
# P words fill the instruction ROM from address 0, E records are stores in program order
D 00000200 80f17f23
D 00000204 00000007
T alu
P 20010005
P 2002fff0
P 00221820
P ac030100
P 0022202b
P 00412807
P ac040104
P ac050108
P 30468f0f
P 38c7ffff
P ac07010c
P ac060114
P 0041402a
P 00414806
P 01285022
P ac0a0110
E 00000100 fffffff5 f
E 00000104 00000001 f
E 00000108 ffffffff f
E 0000010c 000070ff f
E 00000114 00008f00 f
E 00000110 07fffffe f
T loads
P 8c010200
P ac010120
P 80020202
P 90030203
P 84040202
P 94050200
P 00a43020
P ac060124
P ac020128
P ac03012c
P 3c071234
P 34e7abcd
P a0070131
P a4070136
P a4040138
P 8c080130
P ac08013c
E 00000120 80f17f23 f
E 00000124 00000014 f
E 00000128 fffffff1 f
E 0000012c 00000080 f
E 00000130 cdcdcdcd 2
E 00000134 abcdabcd c
E 00000138 80f180f1 3
E 0000013c 0000cd00 f
T branches
P 10000008
P 20090011
P 200900ee
P 14000004
P 200a0022
P 214a0100
P ac090140
P ac0a0144
P 8c020204
P 14400008
P 20430001
P 20030bad
P 0c000010
P ac030148
P ac040150
P 08000010
P 00000000
P ac1f014c
P 4be00000
P 20040033
P 200500e4
P 4ca00000
P 20060044
P 20060bad
P ac1f0154
P ac060158
P 10c00008
P 20070055
P ac07015c
P 0bfffffc
P 00000000
E 00000140 00000011 f
E 00000144 00000122 f
E 00000148 00000008 f
E 0000014c 000000bc f
E 00000150 00000033 f
E 00000154 000000e0 f
E 00000158 00000044 f
E 0000015c 00000055 f

//--- testbench/tb_dlx_pipeline.sv
`timescale 1ns/1ps

module tb_dlx_pipeline;
  import dlx_pkg::*;

  localparam int rom_words = 256;
  localparam int mem_words = 256;
  localparam int max_recs  = 64;
  localparam int max_tests = 16;

  logic        clk;
  logic        arst_n;
  logic [31:0] pc;
  logic [31:0] instr;
  apb_req_t    apb_req;
  logic [31:0] prdata;
  logic        pready;

  // program, data memory and expected stores
  logic [31:0]     rom [rom_words];
  logic [31:0]     mem [mem_words];
  logic [31:0]     d_addr [max_recs];
  logic [31:0]     d_data [max_recs];
  logic [31:0]     exp_addr [max_recs];
  logic [31:0]     exp_data [max_recs];
  logic [3:0]      exp_strb [max_recs];
  int              exp_test [max_recs];
  logic [8*24-1:0] test_name [max_tests];
  int              test_errs [max_tests];

  int     n_prog;
  int     n_data;
  int     n_exp;
  int     n_tests;
  int     exp_idx;
  int     run;
  int     checks;
  int     errors;
  int     wait_left;
  logic   random_waits;
  logic   loaded;
  integer seed;

  dlx_pipeline i_dlx_pipeline (
    .clk     (clk),
    .arst_n  (arst_n),
    .pc      (pc),
    .instr   (instr),
    .apb_req (apb_req),
    .prdata  (prdata),
    .pready  (pready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // test file
  //////////////////////////////////////////////////
  task automatic load_tests();
    int               fd;
    int               r;
    logic [8*24-1:0]  tok;
    logic [8*128-1:0] line;
    logic [31:0]      a;
    logic [31:0]      d;
    logic [3:0]       s;
    for (int i = 0; i < rom_words; i++) begin
      rom[i] = '0;
    end
    fd = $fopen("testbench/dlx_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test file testbench/dlx_tests.txt");
      errors++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == "#") begin
          // rest of the line is a comment
          r = $fgets(line, fd);
        end else if (tok == "T") begin
          r = $fscanf(fd, "%s", tok);
          test_name[n_tests] = tok;
          n_tests++;
        end else if (tok == "P") begin
          r = $fscanf(fd, "%h", a);
          rom[n_prog] = a;
          n_prog++;
        end else if (tok == "D") begin
          r = $fscanf(fd, "%h %h", a, d);
          d_addr[n_data] = a;
          d_data[n_data] = d;
          n_data++;
        end else if (tok == "E") begin
          r = $fscanf(fd, "%h %h %h", a, d, s);
          exp_addr[n_exp] = a;
          exp_data[n_exp] = d;
          exp_strb[n_exp] = s;
          exp_test[n_exp] = n_tests - 1;
          n_exp++;
        end else begin
          $display("unknown record kind %0s in the test file", tok);
          errors++;
        end
      end
      $fclose(fd);
      if (n_exp == 0) begin
        $display("the test file holds no expected stores");
        errors++;
      end
    end
  endtask

  // zeroed memory plus the D records
  task automatic preload_memory();
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = '0;
    end
    for (int i = 0; i < n_data; i++) begin
      mem[d_addr[i][9:2]] = d_data[i];
    end
  endtask

  //////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////
  task automatic compare(input string name, input logic [31:0] got,
                         input logic [31:0] expected, input int t);
    checks++;
    if (got !== expected) begin
      $display("MISMATCH %0s: got %h, expected %h", name, got, expected);
      errors++;
      test_errs[t]++;
    end
  endtask

  task automatic check_store(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    int t;
    if (exp_idx >= n_exp) begin
      $display("run %0d: store to address %h comes after the last expected store", run, addr);
      errors++;
    end else begin
      t = exp_test[exp_idx];
      compare("paddr", addr, exp_addr[exp_idx], t);
      compare("pwdata", data, exp_data[exp_idx], t);
      compare("pstrb", {28'h0, strb}, {28'h0, exp_strb[exp_idx]}, t);
      exp_idx++;
      // last store of this test just went by
      if (exp_idx == n_exp || exp_test[exp_idx] != t) begin
        $display("run %0d test %0s: done, %0d mismatches", run, test_name[t], test_errs[t]);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // apb slave and instruction port
  //////////////////////////////////////////////////
  task automatic serve_apb();
    logic [7:0] w;
    w      = apb_req.paddr[9:2];
    pready = 1'b0;
    if (apb_req.psel && !apb_req.penable) begin
      // setup, pick wait states for this transfer
      wait_left = random_waits ? ($random(seed) & 3) : 0;
    end else if (apb_req.psel && wait_left > 0) begin
      wait_left--;
    end else if (apb_req.psel) begin
      pready = 1'b1;
      if (apb_req.pwrite) begin
        for (int b = 0; b < 4; b++) begin
          if (apb_req.pstrb[b]) mem[w][8*b +: 8] = apb_req.pwdata[8*b +: 8];
        end
        check_store(apb_req.paddr, apb_req.pwdata, apb_req.pstrb);
      end else begin
        prdata = mem[w];
      end
    end
  endtask

  // pc and apb request settle after the edge
  always @(posedge clk) begin
    #2;
    instr = rom[pc[9:2]];
    serve_apb();
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    arst_n       = 1'b0;
    instr        = '0;
    prdata       = '0;
    pready       = 1'b0;
    seed         = 32'hf318;
    checks       = 0;
    errors       = 0;
    n_prog       = 0;
    n_data       = 0;
    n_exp        = 0;
    n_tests      = 0;
    exp_idx      = 0;
    run          = 0;
    wait_left    = 0;
    random_waits = 1'b0;
    loaded       = 1'b0;
    load_tests();
    loaded = 1'b1;
    if (errors == 0) begin
      for (run = 0; run < 2; run++) begin
        // second run stretches transfers with wait states
        random_waits = (run == 1);
        @(posedge clk);
        #2;
        arst_n = 1'b0;
        preload_memory();
        exp_idx = 0;
        for (int t = 0; t < n_tests; t++) begin
          test_errs[t] = 0;
        end
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;
        wait (exp_idx == n_exp);
        // stray stores after the list show up here
        repeat (50) @(posedge clk);
      end
    end
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // both runs, 40 cycles per instruction word plus slack
  initial begin
    int limit;
    wait (loaded);
    limit = 2 * (40 * n_prog + 200);
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles: %0d expected stores never seen in run %0d",
             limit, n_exp - exp_idx, run);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
